// ==== pct_pkg.sv ====
`default_nettype none

package pct_pkg;

  // --------------------
  // AXI4-Lite control bus
  // --------------------

  localparam int AXIL_DATA_BITS = 64;
  // Byte offset inside one data word
  localparam int ADDR_LSB = $clog2(AXIL_DATA_BITS / 8);
  localparam int N_REGS = 6;
  localparam int REG_IDX_BITS = $clog2(N_REGS);
  // Six 64-bit registers span 48 bytes
  localparam int AXIL_ADDR_BITS = ADDR_LSB + REG_IDX_BITS;
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Register map in word indices
  localparam logic [REG_IDX_BITS-1:0] CTRL_REG = 0;
  localparam logic [REG_IDX_BITS-1:0] STAT_REG = 1;
  localparam logic [REG_IDX_BITS-1:0] SLCT_REG = 2;
  localparam logic [REG_IDX_BITS-1:0] TSUM_REG = 3;
  localparam logic [REG_IDX_BITS-1:0] SSUM_REG = 4;
  localparam logic [REG_IDX_BITS-1:0] SCNT_REG = 5;

  // --------------------
  // Record stream
  // --------------------

  localparam int REC_BITS = 32;
  // Amount in the low bits with the flag field above it
  localparam int AMT_BITS = 24;
  localparam int FLAG_LSB = 24;

  // Totals
  localparam int SUM_BITS = 40;
  localparam int CNT_BITS = 32;

endpackage

`default_nettype wire

// ==== percentage_slv.sv ====
`timescale 1ns/1ps
`default_nettype none

module percentage_slv (
  input  logic                                 aclk,
  input  logic                                 aresetn,
  // Write address
  input  logic [pct_pkg::AXIL_ADDR_BITS-1:0]   s_awaddr,
  input  logic                                 s_awvalid,
  output logic                                 s_awready,
  // Write data
  input  logic [pct_pkg::AXIL_DATA_BITS-1:0]   s_wdata,
  input  logic [pct_pkg::AXIL_DATA_BITS/8-1:0] s_wstrb,
  input  logic                                 s_wvalid,
  output logic                                 s_wready,
  // Write response
  output logic [1:0]                           s_bresp,
  output logic                                 s_bvalid,
  input  logic                                 s_bready,
  // Read address
  input  logic [pct_pkg::AXIL_ADDR_BITS-1:0]   s_araddr,
  input  logic                                 s_arvalid,
  output logic                                 s_arready,
  // Read data
  output logic [pct_pkg::AXIL_DATA_BITS-1:0]   s_rdata,
  output logic [1:0]                           s_rresp,
  output logic                                 s_rvalid,
  input  logic                                 s_rready,
  // Accumulator side
  output logic                                 select,
  output logic                                 clear,
  input  logic                                 done,
  input  logic [pct_pkg::SUM_BITS-1:0]         total_sum,
  input  logic [pct_pkg::SUM_BITS-1:0]         selected_sum,
  input  logic [pct_pkg::CNT_BITS-1:0]         selected_count
);

import pct_pkg::*;

// --------------------
// Declarations
// --------------------

// Write side
logic                      aw_en;
logic                      wr_en;
logic [REG_IDX_BITS-1:0]   wr_idx;
logic                      start_wr;
logic                      done_sts;

// Read side
logic                      rd_en;
logic [REG_IDX_BITS-1:0]   rd_idx;
logic [AXIL_DATA_BITS-1:0] rd_word;

// No error responses on this port
assign s_bresp = RESP_OKAY;
assign s_rresp = RESP_OKAY;

// --------------------
// Write channel
// --------------------

// Address and data are held by the master until both are taken
assign wr_en    = s_awready && s_awvalid && s_wready && s_wvalid;
assign wr_idx   = s_awaddr[AXIL_ADDR_BITS-1:ADDR_LSB];
assign start_wr = wr_en && (wr_idx == CTRL_REG) && s_wstrb[0] && s_wdata[0];

// awready and wready pulse together for one write in flight
always_ff @(posedge aclk)
begin
  if (!aresetn)
  begin
    s_awready <= 1'b0;
    s_wready  <= 1'b0;
    aw_en     <= 1'b1;
  end
  else if (!s_awready && s_awvalid && s_wvalid && aw_en)
  begin
    s_awready <= 1'b1;
    s_wready  <= 1'b1;
    aw_en     <= 1'b0;
  end
  else
  begin
    s_awready <= 1'b0;
    s_wready  <= 1'b0;
    // Next write only after the response is taken
    if (s_bvalid && s_bready)
    begin
      aw_en <= 1'b1;
    end
  end
end

// Write response
always_ff @(posedge aclk)
begin
  if (!aresetn)
  begin
    s_bvalid <= 1'b0;
  end
  else if (wr_en)
  begin
    s_bvalid <= 1'b1;
  end
  else if (s_bready)
  begin
    s_bvalid <= 1'b0;
  end
end

// --------------------
// Control and status
// --------------------

// Start bit self-clears into a one-cycle clear strobe
always_ff @(posedge aclk)
begin
  if (!aresetn)
  begin
    select   <= 1'b0;
    clear    <= 1'b0;
    done_sts <= 1'b0;
  end
  else
  begin
    clear <= start_wr;
    if (wr_en && (wr_idx == SLCT_REG) && s_wstrb[0])
    begin
      select <= s_wdata[0];
    end
    // Sticky done dropped by a new start
    if (start_wr || clear)
    begin
      done_sts <= 1'b0;
    end
    else if (done)
    begin
      done_sts <= 1'b1;
    end
  end
end

// --------------------
// Read channel
// --------------------

assign rd_en  = s_arready && s_arvalid;
assign rd_idx = s_araddr[AXIL_ADDR_BITS-1:ADDR_LSB];

// Held off while a read response is still pending
always_ff @(posedge aclk)
begin
  if (!aresetn)
  begin
    s_arready <= 1'b0;
  end
  else
  begin
    s_arready <= !s_arready && s_arvalid && !s_rvalid;
  end
end

always_ff @(posedge aclk)
begin
  if (!aresetn)
  begin
    s_rvalid <= 1'b0;
  end
  else if (rd_en)
  begin
    s_rvalid <= 1'b1;
  end
  else if (s_rready)
  begin
    s_rvalid <= 1'b0;
  end
end

// Read mux with the totals zero-extended
always_comb
begin
  rd_word = '0;
  case (rd_idx)
    STAT_REG: rd_word[0] = done_sts;
    SLCT_REG: rd_word[0] = select;
    TSUM_REG: rd_word = {{(AXIL_DATA_BITS-SUM_BITS){1'b0}}, total_sum};
    SSUM_REG: rd_word = {{(AXIL_DATA_BITS-SUM_BITS){1'b0}}, selected_sum};
    SCNT_REG: rd_word = {{(AXIL_DATA_BITS-CNT_BITS){1'b0}}, selected_count};
    default:  rd_word = '0;
  endcase
end

// Captured once and stable until rready
always_ff @(posedge aclk)
begin
  if (rd_en)
  begin
    s_rdata <= rd_word;
  end
end

endmodule

`default_nettype wire

// ==== percentage_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

module percentage_acc (
  input  logic                         aclk,
  input  logic                         aresetn,
  input  logic                         select,
  input  logic                         clear,
  // Record stream without back-pressure
  input  logic                         rec_valid,
  input  logic [pct_pkg::REC_BITS-1:0] rec_data,
  input  logic                         rec_last,
  // Results
  output logic                         done,
  output logic [pct_pkg::SUM_BITS-1:0] total_sum,
  output logic [pct_pkg::SUM_BITS-1:0] selected_sum,
  output logic [pct_pkg::CNT_BITS-1:0] selected_count
);

import pct_pkg::*;

// --------------------
// Record fields
// --------------------

logic [AMT_BITS-1:0]          amount;
logic [SUM_BITS-1:0]          amount_ext;
logic [REC_BITS-FLAG_LSB-1:0] flags;
logic                         flag_hit;

assign amount     = rec_data[AMT_BITS-1:0];
assign amount_ext = {{(SUM_BITS-AMT_BITS){1'b0}}, amount};
assign flags      = rec_data[REC_BITS-1:FLAG_LSB];

// Flag bit picked by the select setting
assign flag_hit = flags[select];

// --------------------
// Totals
// --------------------

// Sums and count wrap at their widths
always_ff @(posedge aclk)
begin
  if (!aresetn)
  begin
    total_sum      <= '0;
    selected_sum   <= '0;
    selected_count <= '0;
    done           <= 1'b0;
  end
  else if (clear)
  begin
    // A record in the clear cycle is dropped
    total_sum      <= '0;
    selected_sum   <= '0;
    selected_count <= '0;
    done           <= 1'b0;
  end
  else
  begin
    // Totals already final while done is high
    done <= rec_valid && rec_last;
    if (rec_valid)
    begin
      total_sum <= total_sum + amount_ext;
      if (flag_hit)
      begin
        selected_sum   <= selected_sum + amount_ext;
        selected_count <= selected_count + 1'b1;
      end
    end
  end
end

endmodule

`default_nettype wire

// ==== percentage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module percentage_top (
  input  logic                                 aclk,
  input  logic                                 aresetn,
  // AXI4-Lite control slave
  input  logic [pct_pkg::AXIL_ADDR_BITS-1:0]   s_awaddr,
  input  logic                                 s_awvalid,
  output logic                                 s_awready,
  input  logic [pct_pkg::AXIL_DATA_BITS-1:0]   s_wdata,
  input  logic [pct_pkg::AXIL_DATA_BITS/8-1:0] s_wstrb,
  input  logic                                 s_wvalid,
  output logic                                 s_wready,
  output logic [1:0]                           s_bresp,
  output logic                                 s_bvalid,
  input  logic                                 s_bready,
  input  logic [pct_pkg::AXIL_ADDR_BITS-1:0]   s_araddr,
  input  logic                                 s_arvalid,
  output logic                                 s_arready,
  output logic [pct_pkg::AXIL_DATA_BITS-1:0]   s_rdata,
  output logic [1:0]                           s_rresp,
  output logic                                 s_rvalid,
  input  logic                                 s_rready,
  // Record stream
  input  logic                                 rec_valid,
  input  logic [pct_pkg::REC_BITS-1:0]         rec_data,
  input  logic                                 rec_last
);

import pct_pkg::*;

// Between slave and accumulator
logic                select;
logic                clear;
logic                done;
logic [SUM_BITS-1:0] total_sum;
logic [SUM_BITS-1:0] selected_sum;
logic [CNT_BITS-1:0] selected_count;

percentage_slv percentage_slv_inst (
  .aclk           (aclk),
  .aresetn        (aresetn),
  .s_awaddr       (s_awaddr),
  .s_awvalid      (s_awvalid),
  .s_awready      (s_awready),
  .s_wdata        (s_wdata),
  .s_wstrb        (s_wstrb),
  .s_wvalid       (s_wvalid),
  .s_wready       (s_wready),
  .s_bresp        (s_bresp),
  .s_bvalid       (s_bvalid),
  .s_bready       (s_bready),
  .s_araddr       (s_araddr),
  .s_arvalid      (s_arvalid),
  .s_arready      (s_arready),
  .s_rdata        (s_rdata),
  .s_rresp        (s_rresp),
  .s_rvalid       (s_rvalid),
  .s_rready       (s_rready),
  .select         (select),
  .clear          (clear),
  .done           (done),
  .total_sum      (total_sum),
  .selected_sum   (selected_sum),
  .selected_count (selected_count)
);

percentage_acc percentage_acc_inst (
  .aclk           (aclk),
  .aresetn        (aresetn),
  .select         (select),
  .clear          (clear),
  .rec_valid      (rec_valid),
  .rec_data       (rec_data),
  .rec_last       (rec_last),
  .done           (done),
  .total_sum      (total_sum),
  .selected_sum   (selected_sum),
  .selected_count (selected_count)
);

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic aclk,
  output logic aresetn
);

// 40 ns period
initial
begin
  aclk = 1'b0;
  forever
  begin
    #20 aclk = ~aclk;
  end
end

// Reset held low for two rising edges and released on a falling edge
initial
begin
  aresetn = 1'b0;
  repeat (2) @(posedge aclk);
  @(negedge aclk);
  aresetn = 1'b1;
end

endmodule

`default_nettype wire

// ==== percentage_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module percentage_asserts (
  input logic                               aclk,
  input logic                               aresetn,
  input logic                               s_bvalid,
  input logic                               s_bready,
  input logic                               s_rvalid,
  input logic                               s_rready,
  input logic [pct_pkg::AXIL_DATA_BITS-1:0] s_rdata,
  input logic                               done
);

// --------------------
// AXI4-Lite responses
// --------------------

// Write response stays up until taken
bvalid_held: assert property (
  @(posedge aclk) disable iff (!aresetn)
  (s_bvalid && !s_bready) |=> s_bvalid
) else $error("bvalid dropped before bready");

// Read data stays up and unchanged until taken
rvalid_held: assert property (
  @(posedge aclk) disable iff (!aresetn)
  (s_rvalid && !s_rready) |=> (s_rvalid && $stable(s_rdata))
) else $error("rvalid dropped or rdata changed before rready");

// --------------------
// Accumulator
// --------------------

done_single: assert property (
  @(posedge aclk) disable iff (!aresetn)
  done |=> !done
) else $error("done high for more than one cycle");

endmodule

`default_nettype wire

// ==== percentage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module percentage_tb;

import pct_pkg::*;

localparam int BATCH_LEN = 50;
// Well above the length of all six tests
localparam int TIMEOUT_CYCLES = 4000;

logic                        aclk;
logic                        aresetn;
logic [AXIL_ADDR_BITS-1:0]   s_awaddr;
logic                        s_awvalid;
logic                        s_awready;
logic [AXIL_DATA_BITS-1:0]   s_wdata;
logic [AXIL_DATA_BITS/8-1:0] s_wstrb;
logic                        s_wvalid;
logic                        s_wready;
logic [1:0]                  s_bresp;
logic                        s_bvalid;
logic                        s_bready;
logic [AXIL_ADDR_BITS-1:0]   s_araddr;
logic                        s_arvalid;
logic                        s_arready;
logic [AXIL_DATA_BITS-1:0]   s_rdata;
logic [1:0]                  s_rresp;
logic                        s_rvalid;
logic                        s_rready;
logic                        rec_valid;
logic [REC_BITS-1:0]         rec_data;
logic                        rec_last;

logic [31:0]                 lcg_state;
logic [REC_BITS-1:0]         batch [BATCH_LEN];
logic [SUM_BITS-1:0]         exp_tsum;
logic [SUM_BITS-1:0]         exp_ssum;
logic [CNT_BITS-1:0]         exp_scnt;

int cycle_count;
int error_count;
int check_count;
int errors_at_start;
int test_num;
int tests_passed;
int tests_failed;

// Pending read results for the compare process
string                     name_q [$];
logic [AXIL_DATA_BITS-1:0] exp_q [$];
logic [AXIL_DATA_BITS-1:0] act_q [$];
time                       time_q [$];
string                     cmp_name;
logic [AXIL_DATA_BITS-1:0] cmp_exp;
logic [AXIL_DATA_BITS-1:0] cmp_act;
time                       cmp_time;

bind percentage_slv percentage_asserts percentage_asserts_inst (
  .aclk     (aclk),
  .aresetn  (aresetn),
  .s_bvalid (s_bvalid),
  .s_bready (s_bready),
  .s_rvalid (s_rvalid),
  .s_rready (s_rready),
  .s_rdata  (s_rdata),
  .done     (done)
);

tb_clkgen tb_clkgen_inst (
  .aclk    (aclk),
  .aresetn (aresetn)
);

percentage_top percentage_top_inst (
  .aclk      (aclk),
  .aresetn   (aresetn),
  .s_awaddr  (s_awaddr),
  .s_awvalid (s_awvalid),
  .s_awready (s_awready),
  .s_wdata   (s_wdata),
  .s_wstrb   (s_wstrb),
  .s_wvalid  (s_wvalid),
  .s_wready  (s_wready),
  .s_bresp   (s_bresp),
  .s_bvalid  (s_bvalid),
  .s_bready  (s_bready),
  .s_araddr  (s_araddr),
  .s_arvalid (s_arvalid),
  .s_arready (s_arready),
  .s_rdata   (s_rdata),
  .s_rresp   (s_rresp),
  .s_rvalid  (s_rvalid),
  .s_rready  (s_rready),
  .rec_valid (rec_valid),
  .rec_data  (rec_data),
  .rec_last  (rec_last)
);

// --------------------
// Helpers
// --------------------

function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [AXIL_ADDR_BITS-1:0] reg_addr(input logic [REG_IDX_BITS-1:0] idx);
  return AXIL_ADDR_BITS'(idx) << ADDR_LSB;
endfunction

function automatic string reg_name(input logic [REG_IDX_BITS-1:0] idx);
  case (idx)
    CTRL_REG: return "CTRL_REG";
    STAT_REG: return "STAT_REG";
    SLCT_REG: return "SLCT_REG";
    TSUM_REG: return "TSUM_REG";
    SSUM_REG: return "SSUM_REG";
    SCNT_REG: return "SCNT_REG";
    default:  return "unmapped";
  endcase
endfunction

// Expected totals from the amount in the low 24 bits and flag bit 24 + sel
function automatic void ref_totals(input logic [REC_BITS-1:0] recs [BATCH_LEN],
                                   input logic sel,
                                   output logic [SUM_BITS-1:0] tsum,
                                   output logic [SUM_BITS-1:0] ssum,
                                   output logic [CNT_BITS-1:0] scnt);
  logic [AMT_BITS-1:0] amt;
  tsum = '0;
  ssum = '0;
  scnt = '0;
  for (int i = 0; i < BATCH_LEN; i++)
  begin
    amt  = recs[i][AMT_BITS-1:0];
    tsum = tsum + SUM_BITS'(amt);
    if (recs[i][FLAG_LSB + int'(sel)])
    begin
      ssum = ssum + SUM_BITS'(amt);
      scnt = scnt + 1;
    end
  end
endfunction

function automatic void queue_check(input string name,
                                    input logic [AXIL_DATA_BITS-1:0] expected,
                                    input logic [AXIL_DATA_BITS-1:0] actual);
  name_q.push_back(name);
  exp_q.push_back(expected);
  act_q.push_back(actual);
  time_q.push_back($time);
endfunction

task automatic write_reg(input logic [REG_IDX_BITS-1:0] idx,
                         input logic [AXIL_DATA_BITS-1:0] data,
                         input logic [AXIL_DATA_BITS/8-1:0] strb);
  @(negedge aclk);
  s_awaddr  = reg_addr(idx);
  s_awvalid = 1'b1;
  s_wdata   = data;
  s_wstrb   = strb;
  s_wvalid  = 1'b1;
  s_bready  = 1'b0;
  do @(negedge aclk); while (!(s_awready && s_wready));
  // Taken on the coming rising edge
  @(negedge aclk);
  s_awvalid = 1'b0;
  s_wvalid  = 1'b0;
  while (!s_bvalid) @(negedge aclk);
  // OKAY is the only response
  queue_check("s_bresp", '0, AXIL_DATA_BITS'(s_bresp));
  // Response left waiting for one cycle before it is taken
  @(negedge aclk);
  s_bready = 1'b1;
  @(negedge aclk);
  s_bready = 1'b0;
endtask

// Queues each sample of rdata while rready is held low for hold cycles
task automatic read_reg(input logic [REG_IDX_BITS-1:0] idx, input int hold, input bit check,
                        input logic [AXIL_DATA_BITS-1:0] expected,
                        output logic [AXIL_DATA_BITS-1:0] data);
  @(negedge aclk);
  s_araddr  = reg_addr(idx);
  s_arvalid = 1'b1;
  s_rready  = 1'b0;
  do @(negedge aclk); while (!s_arready);
  @(negedge aclk);
  s_arvalid = 1'b0;
  // Address moves away once the read is accepted
  s_araddr  = '0;
  while (!s_rvalid) @(negedge aclk);
  data = s_rdata;
  if (check)
  begin
    queue_check("s_rresp", '0, AXIL_DATA_BITS'(s_rresp));
  end
  for (int i = 0; i <= hold; i++)
  begin
    if (i > 0)
    begin
      @(negedge aclk);
    end
    if (check)
    begin
      queue_check(reg_name(idx), expected, s_rdata);
    end
  end
  s_rready = 1'b1;
  @(negedge aclk);
  s_rready = 1'b0;
endtask

task automatic check_read(input logic [REG_IDX_BITS-1:0] idx,
                          input logic [AXIL_DATA_BITS-1:0] expected);
  logic [AXIL_DATA_BITS-1:0] data;
  read_reg(idx, 0, 1'b1, expected, data);
endtask

// Until the sticky done bit shows up
task automatic poll_done();
  logic [AXIL_DATA_BITS-1:0] sts;
  sts = '0;
  while (!sts[0])
  begin
    read_reg(STAT_REG, 0, 1'b0, '0, sts);
  end
endtask

// One record per cycle with the last one flagged
task automatic send_batch();
  for (int i = 0; i < BATCH_LEN; i++)
  begin
    @(negedge aclk);
    lcg_state = lcg_next(lcg_state);
    batch[i]  = lcg_state;
    rec_valid = 1'b1;
    rec_data  = lcg_state;
    rec_last  = (i == BATCH_LEN - 1);
  end
  @(negedge aclk);
  rec_valid = 1'b0;
  rec_data  = '0;
  rec_last  = 1'b0;
endtask

task automatic report_test(input string name);
  int errs;
  // Lets the compare process drain its queue
  repeat (2) @(negedge aclk);
  errs     = error_count - errors_at_start;
  test_num = test_num + 1;
  if (errs == 0)
  begin
    tests_passed = tests_passed + 1;
    $display("test %0d %s: ok", test_num, name);
  end
  else
  begin
    tests_failed = tests_failed + 1;
    $display("test %0d %s: %0d errors", test_num, name, errs);
  end
  errors_at_start = error_count;
endtask

// --------------------
// Compare and timeout
// --------------------

always @(negedge aclk)
begin
  while (name_q.size() > 0)
  begin
    cmp_name    = name_q.pop_front();
    cmp_exp     = exp_q.pop_front();
    cmp_act     = act_q.pop_front();
    cmp_time    = time_q.pop_front();
    check_count = check_count + 1;
    assert (cmp_act == cmp_exp)
    else
    begin
      $display("CHECK FAILED at %0t: %s expected 0x%0h, actual 0x%0h",
               cmp_time, cmp_name, cmp_exp, cmp_act);
      error_count = error_count + 1;
    end
  end
end

always @(posedge aclk)
begin
  cycle_count <= cycle_count + 1;
  if (cycle_count >= TIMEOUT_CYCLES)
  begin
    $display("ERROR: timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end
end

// --------------------
// Test sequence
// --------------------

initial
begin
  s_awaddr        = '0;
  s_awvalid       = 1'b0;
  s_wdata         = '0;
  s_wstrb         = '0;
  s_wvalid        = 1'b0;
  s_bready        = 1'b0;
  s_araddr        = '0;
  s_arvalid       = 1'b0;
  s_rready        = 1'b0;
  rec_valid       = 1'b0;
  rec_data        = '0;
  rec_last        = 1'b0;
  lcg_state       = 32'hf043_8154;
  cycle_count     = 0;
  error_count     = 0;
  check_count     = 0;
  errors_at_start = 0;
  test_num        = 0;
  tests_passed    = 0;
  tests_failed    = 0;

  wait (aresetn);

  for (int k = 0; k < N_REGS; k++)
  begin
    check_read(REG_IDX_BITS'(k), '0);
  end
  report_test("registers zero after reset");

  send_batch();
  poll_done();
  ref_totals(batch, 1'b0, exp_tsum, exp_ssum, exp_scnt);
  check_read(TSUM_REG, AXIL_DATA_BITS'(exp_tsum));
  check_read(SSUM_REG, AXIL_DATA_BITS'(exp_ssum));
  check_read(SCNT_REG, AXIL_DATA_BITS'(exp_scnt));
  report_test("batch with flag bit 0");

  write_reg(SLCT_REG, 64'd1, 8'hff);
  check_read(SLCT_REG, 64'd1);
  // Register keeps its value without strobes
  write_reg(SLCT_REG, 64'd0, 8'h00);
  check_read(SLCT_REG, 64'd1);
  report_test("select register and strobes");

  write_reg(CTRL_REG, 64'd1, 8'hff);
  check_read(STAT_REG, '0);
  check_read(TSUM_REG, '0);
  check_read(SSUM_REG, '0);
  check_read(SCNT_REG, '0);
  check_read(CTRL_REG, '0);
  report_test("start clears totals and status");

  send_batch();
  poll_done();
  ref_totals(batch, 1'b1, exp_tsum, exp_ssum, exp_scnt);
  check_read(TSUM_REG, AXIL_DATA_BITS'(exp_tsum));
  check_read(SSUM_REG, AXIL_DATA_BITS'(exp_ssum));
  check_read(SCNT_REG, AXIL_DATA_BITS'(exp_scnt));
  report_test("batch with flag bit 1");

  begin : held_read
    logic [AXIL_DATA_BITS-1:0] data;
    read_reg(TSUM_REG, 6, 1'b1, AXIL_DATA_BITS'(exp_tsum), data);
  end
  check_read(SCNT_REG, AXIL_DATA_BITS'(exp_scnt));
  report_test("rdata held while rready low");

  $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
           tests_passed, tests_failed, check_count, error_count);
  if (error_count == 0 && tests_failed == 0)
  begin
    $display("TEST PASSED");
  end
  else
  begin
    $display("TEST FAILED");
  end
  $finish;
end

endmodule

`default_nettype wire

// ==== tb.f ====
pct_pkg.sv
percentage_slv.sv
percentage_acc.sv
percentage_top.sv
tb_clkgen.sv
percentage_asserts.sv
percentage_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module percentage_tb \
  -f tb.f \
  --Mdir obj_dir \
  -o percentage_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/percentage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
